// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and instruction width
`define DBITS       32
// register number width, 16 registers
`define REGNOBITS   4
// immediate field width before sign extension
`define IMMBITS     16

// instruction field positions
`define OP1_MSB     31
`define OP1_LSB     26
`define OP2_MSB     25
`define OP2_LSB     18
// imm overlaps op2 and rd, only one of them is meaningful per opcode
`define IMM_MSB     23
`define IMM_LSB     8
`define RD_MSB      11
`define RD_LSB      8
`define RS_MSB      7
`define RS_LSB      4
`define RT_MSB      3
`define RT_LSB      0

// memory-mapped output devices
`define ADDR_HEX    32'hFFFFF000
`define ADDR_LEDR   32'hFFFFF020
`define HEX_BITS    24
`define LEDR_BITS   10
`define HEX_RESET   24'hFEDEAD

`endif

// File: hdl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

  // data word and register number
  typedef logic [`DBITS-1:0]     word_t;
  typedef logic [`REGNOBITS-1:0] regno_t;

  // primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    ALUR = 6'b000000,
    SW   = 6'b011010,
    ADDI = 6'b100000,
    ANDI = 6'b100100,
    ORI  = 6'b100101,
    XORI = 6'b100110
  } op1_e;

  // alu function for ALUR, inst[25:18]
  // compares sit in the 0x08 group, arithmetic and logic in 0x20
  typedef enum logic [7:0] {
    EQ   = 8'b00001000,
    LT   = 8'b00001001,
    LE   = 8'b00001010,
    NE   = 8'b00001011,
    ADD  = 8'b00100000,
    AND  = 8'b00100100,
    OR   = 8'b00100101,
    XOR  = 8'b00100110,
    SUB  = 8'b00101000,
    NAND = 8'b00101100,
    NOR  = 8'b00101101,
    NXOR = 8'b00101110,
    RSHF = 8'b00110000,
    LSHF = 8'b00110001
  } op2_e;

endpackage

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  core_pkg::regno_t rs_addr,
  input  core_pkg::regno_t rt_addr,
  output core_pkg::word_t  rs_data,
  output core_pkg::word_t  rt_data,
  input  logic             wr_en,
  input  core_pkg::regno_t wr_addr,
  input  core_pkg::word_t  wr_data
);
  import core_pkg::*;

  localparam int NREGS = 1 << `REGNOBITS;

  word_t regs [NREGS];

  // all registers cleared on reset
  // r0 is never written so it stays zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational read ports
  // same-cycle write is not bypassed here, decode forwards from wb_data
  always_comb begin
    rs_data = regs[rs_addr];
    rt_data = regs[rt_addr];
    if (rs_addr == '0) begin
      rs_data = '0;
    end
    if (rt_addr == '0) begin
      rt_data = '0;
    end
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             inst_valid,
  input  core_pkg::word_t  inst,
  input  core_pkg::word_t  alu_result,
  input  core_pkg::word_t  wb_data,
  input  logic             wb_wr_en,
  input  core_pkg::regno_t wb_regno,
  output logic             id_valid,
  output core_pkg::op1_e   op1,
  output core_pkg::op2_e   op2,
  output core_pkg::word_t  imm_sxt,
  output core_pkg::word_t  opnd_a,
  output core_pkg::word_t  opnd_b,
  output core_pkg::regno_t wregno
);
  import core_pkg::*;

  op1_e                op1_w;
  op2_e                op2_w;
  logic [`IMMBITS-1:0] imm_w;
  regno_t              rd_w;
  regno_t              rs_w;
  regno_t              rt_w;
  word_t               sxt_w;
  word_t               rs_rf;
  word_t               rt_rf;
  word_t               rs_val;
  word_t               rt_val;
  logic                writes_w;
  regno_t              wregno_w;
  // latched instruction has a nonzero destination
  logic                id_writes;

  // field split, unknown codes keep their raw value
  assign op1_w = op1_e'(inst[`OP1_MSB:`OP1_LSB]);
  assign op2_w = op2_e'(inst[`OP2_MSB:`OP2_LSB]);
  assign imm_w = inst[`IMM_MSB:`IMM_LSB];
  assign rd_w  = inst[`RD_MSB:`RD_LSB];
  assign rs_w  = inst[`RS_MSB:`RS_LSB];
  assign rt_w  = inst[`RT_MSB:`RT_LSB];

  assign sxt_w = {{(`DBITS-`IMMBITS){imm_w[`IMMBITS-1]}}, imm_w};

  // destination: rd for ALUR, rt for immediate ops, none otherwise
  always_comb begin
    writes_w = 1'b0;
    wregno_w = '0;
    case (op1_w)
      ALUR: begin
        writes_w = op2_w inside {EQ, LT, LE, NE, ADD, AND, OR, XOR,
                                 SUB, NAND, NOR, NXOR, RSHF, LSHF};
        wregno_w = rd_w;
      end
      ADDI, ANDI, ORI, XORI: begin
        writes_w = 1'b1;
        wregno_w = rt_w;
      end
      default: writes_w = 1'b0;
    endcase
    // r0 writes are dropped, so they never forward either
    if (!writes_w || (wregno_w == '0)) begin
      writes_w = 1'b0;
      wregno_w = '0;
    end
  end

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs_w),
    .rt_addr (rt_w),
    .rs_data (rs_rf),
    .rt_data (rt_rf),
    .wr_en   (wb_wr_en),
    .wr_addr (wb_regno),
    .wr_data (wb_data)
  );

  // operand pick: younger producer in execute first, then writeback
  function automatic word_t fwd_sel(input regno_t src, input word_t rf_val);
    if (id_writes && (wregno == src)) begin
      return alu_result;
    end else if (wb_wr_en && (wb_regno == src)) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs_val = fwd_sel(rs_w, rs_rf);
    rt_val = fwd_sel(rt_w, rt_rf);
  end

  // decode latch control, a bubble clears valid and the writes flag
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_valid  <= 1'b0;
      id_writes <= 1'b0;
      wregno    <= '0;
    end else begin
      id_valid  <= inst_valid;
      id_writes <= inst_valid && writes_w;
      wregno    <= inst_valid ? wregno_w : '0;
    end
  end

  // decode latch payload
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      op1     <= op1_w;
      op2     <= op2_w;
      imm_sxt <= sxt_w;
      opnd_a  <= rs_val;
      opnd_b  <= rt_val;
    end
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             id_valid,
  input  core_pkg::op1_e   op1,
  input  core_pkg::op2_e   op2,
  input  core_pkg::word_t  imm_sxt,
  input  core_pkg::word_t  opnd_a,
  input  core_pkg::word_t  opnd_b,
  input  core_pkg::regno_t wregno,
  output core_pkg::word_t  alu_result,
  output logic             wb_wr_en,
  output core_pkg::regno_t wb_regno,
  output core_pkg::word_t  wb_data,
  output logic             store_en,
  output core_pkg::word_t  store_addr,
  output core_pkg::word_t  store_data
);
  import core_pkg::*;

  localparam int SHBITS = $clog2(`DBITS);

  // shared adder for ADDI and the store address
  word_t sum_imm;
  // known instruction that produces a register result
  logic  result_wr;
  logic  big_shift;

  assign sum_imm   = opnd_a + imm_sxt;
  // any shift amount of DBITS or more clears the word
  assign big_shift = (opnd_b >= `DBITS);

  always_comb begin
    result_wr = 1'b1;
    case (op1)
      ALUR: begin
        case (op2)
          // compares give 0 or 1, LT and LE are signed
          EQ:   alu_result = word_t'(opnd_a == opnd_b);
          LT:   alu_result = word_t'($signed(opnd_a) < $signed(opnd_b));
          LE:   alu_result = word_t'($signed(opnd_a) <= $signed(opnd_b));
          NE:   alu_result = word_t'(opnd_a != opnd_b);
          ADD:  alu_result = opnd_a + opnd_b;
          AND:  alu_result = opnd_a & opnd_b;
          OR:   alu_result = opnd_a | opnd_b;
          XOR:  alu_result = opnd_a ^ opnd_b;
          SUB:  alu_result = opnd_a - opnd_b;
          NAND: alu_result = ~(opnd_a & opnd_b);
          NOR:  alu_result = ~(opnd_a | opnd_b);
          NXOR: alu_result = ~(opnd_a ^ opnd_b);
          // logical right shift
          RSHF: alu_result = big_shift ? '0 : (opnd_a >> opnd_b[SHBITS-1:0]);
          LSHF: alu_result = big_shift ? '0 : (opnd_a << opnd_b[SHBITS-1:0]);
          default: begin
            alu_result = '0;
            result_wr  = 1'b0;
          end
        endcase
      end
      ADDI: alu_result = sum_imm;
      ANDI: alu_result = opnd_a & imm_sxt;
      ORI:  alu_result = opnd_a | imm_sxt;
      XORI: alu_result = opnd_a ^ imm_sxt;
      // store goes to io_ports, not to a register
      SW: begin
        alu_result = sum_imm;
        result_wr  = 1'b0;
      end
      default: begin
        alu_result = '0;
        result_wr  = 1'b0;
      end
    endcase
  end

  // store path to the output devices, rt carries the data
  assign store_en   = id_valid && (op1 == SW);
  assign store_addr = sum_imm;
  assign store_data = opnd_b;

  // writeback latch control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_wr_en <= 1'b0;
      wb_regno <= '0;
    end else begin
      wb_wr_en <= id_valid && result_wr && (wregno != '0);
      wb_regno <= wregno;
    end
  end

  // writeback result, qualified by wb_wr_en downstream
  always_ff @(posedge clk) begin
    wb_data <= alu_result;
  end

endmodule

// File: hdl/io_ports.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module io_ports (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  store_en,
  input  core_pkg::word_t       store_addr,
  input  core_pkg::word_t       store_data,
  output logic [`LEDR_BITS-1:0] ledr,
  output logic [`HEX_BITS-1:0]  hex
);
  import core_pkg::*;

  logic ledr_hit;
  logic hex_hit;

  // full 32-bit address match, anything else is dropped
  assign ledr_hit = store_en && (store_addr == `ADDR_LEDR);
  assign hex_hit  = store_en && (store_addr == `ADDR_HEX);

  // red leds take the low bits of the stored word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
    end else if (ledr_hit) begin
      ledr <= store_data[`LEDR_BITS-1:0];
    end
  end

  // hex display value, six digits
  // comes up showing FEDEAD until the first store
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= `HEX_RESET;
    end else if (hex_hit) begin
      hex <= store_data[`HEX_BITS-1:0];
    end
  end

endmodule

// File: hdl/pipe_alu_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module pipe_alu_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inst_valid,
  input  core_pkg::word_t       inst,
  output logic [`LEDR_BITS-1:0] ledr,
  output logic [`HEX_BITS-1:0]  hex
);
  import core_pkg::*;

  // decode latch to execute
  logic   id_valid;
  op1_e   op1;
  op2_e   op2;
  word_t  imm_sxt;
  word_t  opnd_a;
  word_t  opnd_b;
  regno_t wregno;

  // execute back to decode, forwarding and register write
  word_t  alu_result;
  logic   wb_wr_en;
  regno_t wb_regno;
  word_t  wb_data;

  // execute to output devices
  logic   store_en;
  word_t  store_addr;
  word_t  store_data;

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .alu_result (alu_result),
    .wb_data    (wb_data),
    .wb_wr_en   (wb_wr_en),
    .wb_regno   (wb_regno),
    .id_valid   (id_valid),
    .op1        (op1),
    .op2        (op2),
    .imm_sxt    (imm_sxt),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .wregno     (wregno)
  );

  execute_stage u_execute (
    .clk        (clk),
    .reset      (reset),
    .id_valid   (id_valid),
    .op1        (op1),
    .op2        (op2),
    .imm_sxt    (imm_sxt),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .wregno     (wregno),
    .alu_result (alu_result),
    .wb_wr_en   (wb_wr_en),
    .wb_regno   (wb_regno),
    .wb_data    (wb_data),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data)
  );

  io_ports u_io (
    .clk        (clk),
    .reset      (reset),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data),
    .ledr       (ledr),
    .hex        (hex)
  );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);
  localparam int RESET_CYCLES = 8;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset spans the first eight rising edges, released just after the last one
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: verif/core_assert.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_assert (
  input logic                  clk,
  input logic                  reset,
  input logic                  inst_valid,
  input core_pkg::word_t       inst,
  input logic                  store_en,
  input logic [`LEDR_BITS-1:0] ledr,
  input logic [`HEX_BITS-1:0]  hex
);
  import core_pkg::*;

  // a store instruction taken at this edge
  logic sw_taken;
  // number of assertion failures so far
  int   fail_count = 0;

  assign sw_taken = inst_valid && (inst[`OP1_MSB:`OP1_LSB] == SW);

  // device outputs always hold known values out of reset
  no_unknown_out: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({ledr, hex}))
    else begin
      fail_count++;
      $error("ledr or hex holds an unknown value");
    end

  // a change is seen two samples after the store was taken
  change_needs_sw: assert property (@(posedge clk) disable iff (reset)
    ($changed(ledr) || $changed(hex)) |-> $past(sw_taken, 2))
    else begin
      fail_count++;
      $error("ledr or hex changed without a store one cycle earlier");
    end

  // store strobe stays quiet while reset is applied
  no_store_in_reset: assert property (@(posedge clk) reset |-> !$rose(store_en))
    else begin
      fail_count++;
      $error("store_en rose while reset was high");
    end

endmodule

bind pipe_alu_core core_assert u_core_assert (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .inst       (inst),
  .store_en   (store_en),
  .ledr       (ledr),
  .hex        (hex)
);

// File: verif/tb_checker.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inst_valid,
  input  core_pkg::word_t       inst,
  input  logic [`LEDR_BITS-1:0] ledr,
  input  logic [`HEX_BITS-1:0]  hex,
  output int                    checks,
  output int                    errors,
  output logic                  busy
);
  import core_pkg::*;

  // model state after every instruction taken so far
  word_t                 regs [16];
  logic [`LEDR_BITS-1:0] m_ledr;
  logic [`HEX_BITS-1:0]  m_hex;
  // what the DUT outputs should show before the current edge
  logic [`LEDR_BITS-1:0] vis_ledr;
  logic [`HEX_BITS-1:0]  vis_hex;
  int                    idle;
  int                    n_checks = 0;
  int                    n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;
  // last instruction not yet seen on the outputs
  assign busy   = (idle < 3);

  // expected ALU result, writes goes low for anything that leaves registers alone
  function automatic word_t ref_result(input word_t ins, input word_t a, input word_t b,
                                       output logic writes);
    word_t imm;
    imm = {{16{ins[23]}}, ins[23:8]};
    writes = 1'b1;
    case (ins[31:26])
      ALUR: begin
        case (ins[25:18])
          EQ:   return {31'd0, a == b};
          LT:   return {31'd0, $signed(a) < $signed(b)};
          LE:   return {31'd0, $signed(a) <= $signed(b)};
          NE:   return {31'd0, a != b};
          ADD:  return a + b;
          AND:  return a & b;
          OR:   return a | b;
          XOR:  return a ^ b;
          SUB:  return a - b;
          NAND: return ~(a & b);
          NOR:  return ~(a | b);
          NXOR: return ~(a ^ b);
          // shifting by the full word or more leaves zero
          RSHF: return a >> b;
          LSHF: return a << b;
          default: writes = 1'b0;
        endcase
      end
      ADDI: return a + imm;
      ANDI: return a & imm;
      ORI:  return a | imm;
      XORI: return a ^ imm;
      default: writes = 1'b0;
    endcase
    return '0;
  endfunction

  task automatic reset_model();
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    m_ledr   = '0;
    m_hex    = `HEX_RESET;
    vis_ledr = '0;
    vis_hex  = `HEX_RESET;
    idle     = 0;
  endtask

  // architectural effect of one instruction
  task automatic apply_inst(input word_t ins);
    word_t  a;
    word_t  b;
    word_t  res;
    word_t  addr;
    logic   wr;
    regno_t dst;
    a   = regs[ins[7:4]];
    b   = regs[ins[3:0]];
    res = ref_result(ins, a, b, wr);
    // rd for register ops, rt for immediate ops
    dst = (ins[31:26] == ALUR) ? ins[11:8] : ins[3:0];
    if (wr && (dst != 4'd0)) begin
      regs[dst] = res;
    end
    if (ins[31:26] == SW) begin
      addr = a + {{16{ins[23]}}, ins[23:8]};
      if (addr == `ADDR_LEDR) begin
        m_ledr = b[`LEDR_BITS-1:0];
      end else if (addr == `ADDR_HEX) begin
        m_hex = b[`HEX_BITS-1:0];
      end
    end
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // outputs read here still hold their pre-edge values
  always @(posedge clk) begin
    if (reset) begin
      reset_model();
    end else begin
      check_value("ledr", word_t'(ledr), word_t'(vis_ledr));
      check_value("hex", word_t'(hex), word_t'(vis_hex));
      // stores taken last edge land on the outputs at this edge
      vis_ledr = m_ledr;
      vis_hex  = m_hex;
      if (inst_valid) begin
        apply_inst(inst);
        idle = 0;
      end else if (idle < 100) begin
        idle++;
      end
    end
  end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_top;
  import core_pkg::*;

  logic                  clk;
  logic                  reset;
  logic                  inst_valid;
  word_t                 inst;
  logic [`LEDR_BITS-1:0] ledr;
  logic [`HEX_BITS-1:0]  hex;
  int                    checks;
  int                    errors;
  logic                  busy;
  logic                  ok;
  int                    err_mark;

  op2_e op2_list [14] = '{EQ, LT, LE, NE, ADD, AND, OR, XOR, SUB, NAND, NOR, NXOR, RSHF, LSHF};
  op1_e imm_ops [4]   = '{ADDI, ANDI, ORI, XORI};

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  pipe_alu_core UUT (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .ledr       (ledr),
    .hex        (hex)
  );

  tb_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .ledr       (ledr),
    .hex        (hex),
    .checks     (checks),
    .errors     (errors),
    .busy       (busy)
  );

  function automatic word_t alur_inst(op2_e f, regno_t rd, regno_t rs, regno_t rt);
    return {ALUR, f, 6'd0, rd, rs, rt};
  endfunction

  // immediate ops and SW share this layout
  function automatic word_t imm_inst(op1_e op, regno_t rt, regno_t rs, logic [15:0] imm);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  // drive 1 ns after the edge so the DUT samples settled values
  task automatic send(input word_t ins);
    @(posedge clk);
    #1;
    inst_valid = 1'b1;
    inst       = ins;
  endtask

  // a bubble carries junk that must be ignored
  task automatic bubble();
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
    inst       = $urandom;
  endtask

  // random 32-bit value built as (imm << 16) ^ imm, needs r15 = 16
  task automatic load_random(input regno_t r);
    send(imm_inst(ADDI, r, 4'd0, 16'($urandom)));
    send(alur_inst(LSHF, r, r, 4'd15));
    send(imm_inst(XORI, r, r, 16'($urandom)));
  endtask

  // 0xF000 and 0xF020 sign-extend to the device addresses
  task automatic store_both(input regno_t r);
    send(imm_inst(SW, r, 4'd0, 16'hF000));
    send(imm_inst(SW, r, 4'd0, 16'hF020));
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (reset && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      $display("timeout: reset was never released");
      ok = 1'b0;
    end
  endtask

  // bubbles until the checker has seen the last result on the outputs
  task automatic drain();
    int n;
    n = 0;
    while (busy && n < 10) begin
      bubble();
      n++;
    end
    if (busy) begin
      $display("timeout: pipeline results never reached the outputs");
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    drain();
    $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    inst_valid = 1'b0;
    inst       = '0;
    ok         = 1'b1;
    err_mark   = 0;
    void'($urandom(32'hbfcdad7f));
    wait_reset();
    if (ok) begin
      // reset values hold under bubbles
      repeat (20) bubble();
      finish_test("reset_and_bubbles");

      // every register op2 function, shift amounts up to 40
      send(imm_inst(ADDI, 4'd15, 4'd0, 16'd16));
      foreach (op2_list[i]) begin
        repeat (4) begin
          load_random(4'd1);
          load_random(4'd2);
          if (op2_list[i] inside {RSHF, LSHF} && $urandom_range(3) != 0) begin
            send(imm_inst(ADDI, 4'd2, 4'd0, 16'($urandom_range(40))));
          end
          send(alur_inst(op2_list[i], 4'd3, 4'd1, ($urandom_range(3) == 0) ? 4'd1 : 4'd2));
          store_both(4'd3);
        end
      end
      finish_test("alu_register_ops");

      repeat (24) begin
        load_random(4'd1);
        send(imm_inst(imm_ops[$urandom_range(3)], 4'd3, 4'd1, 16'($urandom)));
        store_both(4'd3);
      end
      finish_test("alu_immediate_ops");

      // mode 0 fills the gap with unrelated work, mode 1 with bubbles
      for (int d = 1; d <= 3; d++) begin
        for (int mode = 0; mode < 2; mode++) begin
          send(imm_inst(ADDI, 4'd4, 4'd0, 16'($urandom)));
          repeat (d - 1) begin
            if (mode == 0) begin
              send(imm_inst(ADDI, 4'd6, 4'd6, 16'd1));
            end else begin
              bubble();
            end
          end
          send(alur_inst(ADD, 4'd5, 4'd4, 4'd4));
          store_both(4'd5);
        end
      end
      // younger producer must win over the older one
      send(imm_inst(ADDI, 4'd4, 4'd0, 16'd7));
      send(imm_inst(ADDI, 4'd4, 4'd4, 16'd3));
      send(alur_inst(ADD, 4'd5, 4'd4, 4'd4));
      store_both(4'd5);
      finish_test("forwarding_chains");

      load_random(4'd1);
      send(alur_inst(ADD, 4'd0, 4'd1, 4'd1));
      send(imm_inst(ADDI, 4'd0, 4'd0, 16'h1234));
      store_both(4'd0);
      send(alur_inst(ADD, 4'd3, 4'd0, 4'd0));
      store_both(4'd3);
      send(imm_inst(ORI, 4'd3, 4'd0, 16'h00FF));
      store_both(4'd3);
      // stores that miss both devices
      send(imm_inst(SW, 4'd1, 4'd0, 16'hF010));
      send(imm_inst(SW, 4'd1, 4'd0, 16'hF024));
      send(imm_inst(SW, 4'd1, 4'd0, 16'h0000));
      repeat (8) send({6'b111111 ^ 6'($urandom_range(3)), 26'($urandom)});
      // unknown op2 must not write r7
      send({ALUR, 8'hFF, 6'd0, 4'd7, 4'd1, 4'd1});
      store_both(4'd7);
      finish_test("r0_and_ignored_ops");

      repeat (400) begin
        case ($urandom_range(3))
          0: send(alur_inst(op2_list[$urandom_range(13)], 4'($urandom), 4'($urandom),
                            4'($urandom)));
          1: send(imm_inst(imm_ops[$urandom_range(3)], 4'($urandom), 4'($urandom),
                           16'($urandom)));
          2: send(imm_inst(SW, 4'($urandom), 4'd0,
                           ($urandom_range(1) == 0) ? 16'hF000 : 16'hF020));
          default: send(imm_inst(SW, 4'($urandom), 4'($urandom), 16'($urandom)));
        endcase
      end
      finish_test("random_mix");
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             UUT.u_core_assert.fail_count);
    if (ok && errors == 0 && UUT.u_core_assert.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: pipe_alu_core.f
+incdir+include
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/io_ports.sv
hdl/pipe_alu_core.sv
verif/tb_clock.sv
verif/core_assert.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= pipe_alu_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
